//--- icache_refill.f
logic/icache_refill_pkg.sv
logic/r_beat_router.sv
logic/miss_slot.sv
logic/ar_arbiter.sv
logic/icache_refill_top.sv
bench/tb_icache_refill.sv

//--- Makefile
# Verilator flow for the instruction cache refill path

VERILATOR  ?= verilator
TOP        := tb_icache_refill
RTL_TOP    := icache_refill_top
FILELIST   := icache_refill.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_refill;

   import icache_refill_pkg::*;

   localparam int NB_CORES     = 4;
   localparam int NB_SLOTS     = NB_CORES + 1;
   localparam int ID_WIDTH     = $clog2(NB_SLOTS);
   localparam int CLK_HALF     = 10;    // 20 ns period
   localparam int RESET_CYCLES = 3;
   localparam int STALL_ROUNDS = 4;     // All-port rounds under AR back-pressure
   localparam int RAND_ROUNDS  = 40;
   localparam int GAP_PCT      = 30;    // Chance of an idle R cycle
   // Each miss of every test gets the worst slave delay
   localparam int MAX_MISSES   = 2 + NB_SLOTS * (1 + STALL_ROUNDS + RAND_ROUNDS);
   localparam int WORST_MISS   = 60;
   localparam int TIMEOUT      = MAX_MISSES * WORST_MISS;

   logic                       clk;
   logic                       rst;
   logic [NB_CORES-1:0]        fetch_req;
   fetch_addr_t [NB_CORES-1:0] fetch_addr;
   logic [NB_CORES-1:0]        fetch_gnt;
   logic [NB_CORES-1:0]        fetch_rvalid;
   line_t [NB_CORES-1:0]       fetch_rdata;
   logic                       pf_req;
   fetch_addr_t                pf_addr;
   logic                       pf_gnt;
   logic                       pf_rvalid;
   line_t                      pf_rdata;
   logic [ID_WIDTH-1:0]        arid;
   fetch_addr_t                araddr;
   logic [7:0]                 arlen;
   logic [2:0]                 arsize;
   logic [1:0]                 arburst;
   logic                       arvalid;
   logic                       arready = 1'b0;  // Slave side starts quiet
   logic [ID_WIDTH-1:0]        rid     = '0;
   beat_t                      rdata   = '0;
   logic                       rlast   = 1'b0;
   logic                       rvalid  = 1'b0;
   logic                       rready;

   // Per-slot view with the prefetcher on the top index
   logic [NB_SLOTS-1:0]        slot_req;
   fetch_addr_t [NB_SLOTS-1:0] slot_addr;
   logic [NB_SLOTS-1:0]        slot_gnt;
   logic [NB_SLOTS-1:0]        slot_rvalid;
   line_t [NB_SLOTS-1:0]       slot_rdata;
   assign slot_req    = {pf_req, fetch_req};
   assign slot_addr   = {pf_addr, fetch_addr};
   assign slot_gnt    = {pf_gnt, fetch_gnt};
   assign slot_rvalid = {pf_rvalid, fetch_rvalid};
   assign slot_rdata  = {pf_rdata, fetch_rdata};

   // Scoreboard written by the compare process
   fetch_addr_t         exp_addr [NB_SLOTS];  // Address at the taken grant
   logic [NB_SLOTS-1:0] outstanding;
   int                  take_count [NB_SLOTS];
   int                  resp_count [NB_SLOTS];
   logic [ID_WIDTH-1:0] ar_order [$];         // Accepted AR IDs in order
   int                  mon_errs = 0;
   int                  cycle_count = 0;
   logic                arvalid_prev;
   logic                arready_prev;
   fetch_addr_t         araddr_prev;
   logic [ID_WIDTH-1:0] arid_prev;

   // Stimulus side
   fetch_addr_t next_addr [NB_SLOTS];
   int          ready_pct = 100;              // arready high chance in percent
   int          test_errs = 0;
   int          test_count = 0;
   int          test_fails = 0;
   int          err_mark;
   int          ar_mark;
   int          resp_before [NB_SLOTS];
   string       test_name;

   // Slave burst table with one entry per ID
   logic [NB_SLOTS-1:0] burst_open;
   fetch_addr_t         burst_addr [NB_SLOTS];
   int                  burst_beat [NB_SLOTS];

   icache_refill_top #(
      .NB_CORES          (NB_CORES)
   ) icache_refill_top_i (
      .clk               (clk),
      .rst_i             (rst),
      .fetch_req_i       (fetch_req),
      .fetch_addr_i      (fetch_addr),
      .fetch_gnt_o       (fetch_gnt),
      .fetch_rvalid_o    (fetch_rvalid),
      .fetch_rdata_o     (fetch_rdata),
      .pf_fetch_req_i    (pf_req),
      .pf_fetch_addr_i   (pf_addr),
      .pf_fetch_gnt_o    (pf_gnt),
      .pf_fetch_rvalid_o (pf_rvalid),
      .pf_fetch_rdata_o  (pf_rdata),
      .axi_arid_o        (arid),
      .axi_araddr_o      (araddr),
      .axi_arlen_o       (arlen),
      .axi_arsize_o      (arsize),
      .axi_arburst_o     (arburst),
      .axi_arvalid_o     (arvalid),
      .axi_arready_i     (arready),
      .axi_rid_i         (rid),
      .axi_rdata_i       (rdata),
      .axi_rlast_i       (rlast),
      .axi_rvalid_i      (rvalid),
      .axi_rready_o      (rready)
   );

   initial clk = 1'b0;
   always #CLK_HALF clk = ~clk;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic fetch_addr_t line_base(input fetch_addr_t a);
      return a & ~fetch_addr_t'((1 << LINE_OFFSET) - 1);  // 16 byte lines
   endfunction

   // Base in the upper word and the inverted base XOR beat number below
   function automatic beat_t beat_value(input fetch_addr_t base, input int k);
      return {base, ~base ^ fetch_addr_t'(k)};
   endfunction

   function automatic line_t expected_line(input fetch_addr_t addr);
      return {beat_value(line_base(addr), 1), beat_value(line_base(addr), 0)};
   endfunction

   function automatic void report_mismatch(input string sig,
                                           input logic [LINE_WIDTH-1:0] got,
                                           input logic [LINE_WIDTH-1:0] exp);
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, sig, got, exp);
   endfunction

   function automatic string port_name(input int s);
      return (s < NB_CORES) ? $sformatf("fetch port %0d", s) : "prefetch port";
   endfunction

   ////////////////////////////////////////
   // AXI slave model
   ////////////////////////////////////////
   always @(posedge clk) begin
      int open_ids [$];
      int pick;
      if (rst) begin
         burst_open = '0;
         arready   <= 1'b0;
         rvalid    <= 1'b0;
      end else begin
         if (arvalid && arready) begin  // Queue the accepted burst
            burst_open[arid] = 1'b1;
            burst_addr[arid] = araddr;
            burst_beat[arid] = 0;
         end
         arready <= (int'($urandom % 100) < ready_pct);
         open_ids.delete();
         for (int s = 0; s < NB_SLOTS; s++) begin
            if (burst_open[s]) open_ids.push_back(s);
         end
         // Any open burst may send next, so IDs interleave
         if (open_ids.size() > 0 && int'($urandom % 100) >= GAP_PCT) begin
            pick = open_ids[$urandom % open_ids.size()];
            rvalid <= 1'b1;
            rid    <= ID_WIDTH'(pick);
            rdata  <= beat_value(burst_addr[pick], burst_beat[pick]);
            rlast  <= (burst_beat[pick] == 1);
            if (burst_beat[pick] == 1) burst_open[pick] = 1'b0;
            else burst_beat[pick] = 1;
         end else begin
            rvalid <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////
   always @(posedge clk) begin
      cycle_count++;
      if (rst) begin
         outstanding = '0;
         for (int s = 0; s < NB_SLOTS; s++) begin
            take_count[s] = 0;
            resp_count[s] = 0;
         end
      end else begin
         // Responses first since a slot may be granted again in the same cycle
         for (int s = 0; s < NB_SLOTS; s++) begin
            if (slot_rvalid[s]) begin
               resp_count[s]++;
               if (!outstanding[s]) begin
                  $display("ERROR at %0t: %s answered with no request", $time, port_name(s));
                  mon_errs++;
               end else if (slot_rdata[s] !== expected_line(exp_addr[s])) begin
                  report_mismatch((s < NB_CORES) ? $sformatf("fetch_rdata_o[%0d]", s)
                                  : "pf_fetch_rdata_o", slot_rdata[s], expected_line(exp_addr[s]));
                  mon_errs++;
               end
               outstanding[s] = 1'b0;
            end
         end
         // Stalled AR must hold
         if (arvalid_prev && !arready_prev) begin
            if (arvalid !== 1'b1 || araddr !== araddr_prev || arid !== arid_prev) begin
               report_mismatch("axi_arvalid_o/araddr/arid", LINE_WIDTH'({arvalid, araddr, arid}),
                               LINE_WIDTH'({1'b1, araddr_prev, arid_prev}));
               mon_errs++;
            end
         end
         if (arvalid && arready) begin
            ar_order.push_back(arid);
            if (32'(arid) >= NB_SLOTS || !outstanding[arid]) begin
               $display("ERROR at %0t: AR with ID %0d for a slot with no miss", $time, arid);
               mon_errs++;
            end else if (araddr !== line_base(exp_addr[arid])) begin
               report_mismatch("axi_araddr_o", LINE_WIDTH'(araddr),
                               LINE_WIDTH'(line_base(exp_addr[arid])));
               mon_errs++;
            end
            if (arlen !== 8'd1 || arsize !== 3'd3 || arburst !== 2'd1) begin
               report_mismatch("axi_arlen/arsize/arburst_o", LINE_WIDTH'({arlen, arsize, arburst}),
                               LINE_WIDTH'({8'd1, 3'd3, 2'd1}));
               mon_errs++;
            end
         end
         // Grant high exactly when the slot has nothing in flight
         for (int s = 0; s < NB_SLOTS; s++) begin
            if (slot_gnt[s] !== !outstanding[s]) begin
               report_mismatch((s < NB_CORES) ? $sformatf("fetch_gnt_o[%0d]", s)
                               : "pf_fetch_gnt_o", LINE_WIDTH'(slot_gnt[s]),
                               LINE_WIDTH'(!outstanding[s]));
               mon_errs++;
            end
            if (slot_req[s] && slot_gnt[s]) begin  // Taken miss
               exp_addr[s]    = slot_addr[s];
               outstanding[s] = 1'b1;
               take_count[s]++;
            end
         end
      end
      arvalid_prev = arvalid;
      arready_prev = arready;
      araddr_prev  = araddr;
      arid_prev    = arid;
      if (cycle_count >= TIMEOUT) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   task automatic drive_req(input int s, input logic val, input fetch_addr_t a);
      if (s < NB_CORES) begin
         fetch_req[s]  <= val;
         fetch_addr[s] <= a;
      end else begin
         pf_req  <= val;
         pf_addr <= a;
      end
   endtask

   // Hold each masked request until its grant is seen
   task automatic raise_requests(input logic [NB_SLOTS-1:0] mask);
      logic [NB_SLOTS-1:0] left;
      logic [NB_SLOTS-1:0] granted;
      left = mask;
      @(posedge clk);
      for (int s = 0; s < NB_SLOTS; s++) begin
         if (mask[s]) drive_req(s, 1'b1, next_addr[s]);
      end
      while (left != '0) begin
         @(negedge clk);
         granted = left & slot_gnt;
         @(posedge clk);
         for (int s = 0; s < NB_SLOTS; s++) begin
            if (granted[s]) drive_req(s, 1'b0, next_addr[s]);
         end
         left = left & ~granted;
      end
   endtask

   task automatic wait_drained();
      @(negedge clk);
      while (outstanding != '0) @(negedge clk);
   endtask

   task automatic random_addrs();
      for (int s = 0; s < NB_SLOTS; s++) next_addr[s] = fetch_addr_t'($urandom());
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_count++;
      err_mark = test_errs + mon_errs;
      ar_mark  = ar_order.size();
      for (int s = 0; s < NB_SLOTS; s++) resp_before[s] = resp_count[s];
   endtask

   task automatic finish_test();
      if (test_errs + mon_errs == err_mark) begin
         $display("test %0d %s: ok", test_count, test_name);
      end else begin
         test_fails++;
         $display("test %0d %s: %0d errors", test_count, test_name,
                  test_errs + mon_errs - err_mark);
      end
   endtask

   // n responses on each masked slot and none on the others
   task automatic expect_responses(input logic [NB_SLOTS-1:0] mask, input int n);
      for (int s = 0; s < NB_SLOTS; s++) begin
         if (resp_count[s] - resp_before[s] != (mask[s] ? n : 0)) begin
            $display("ERROR at %0t: %s gave %0d responses, expected %0d", $time,
                     port_name(s), resp_count[s] - resp_before[s], mask[s] ? n : 0);
            test_errs++;
         end
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      void'($urandom(52767));
      rst        = 1'b1;
      fetch_req  = '0;
      fetch_addr = '0;
      pf_req     = 1'b0;
      pf_addr    = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      start_test("reset state");
      @(negedge clk);
      if (arvalid !== 1'b0 || fetch_rvalid !== '0 || pf_rvalid !== 1'b0) begin
         report_mismatch("axi_arvalid_o/fetch_rvalid_o/pf_fetch_rvalid_o",
                         LINE_WIDTH'({arvalid, fetch_rvalid, pf_rvalid}), '0);
         test_errs++;
      end
      if (rready !== 1'b1) begin
         report_mismatch("axi_rready_o", LINE_WIDTH'(rready), LINE_WIDTH'(1));
         test_errs++;
      end
      if (slot_gnt !== '1) begin
         report_mismatch("fetch_gnt_o/pf_fetch_gnt_o", LINE_WIDTH'(slot_gnt),
                         LINE_WIDTH'({NB_SLOTS{1'b1}}));
         test_errs++;
      end
      finish_test();

      start_test("single core miss");
      next_addr[2] = 32'h1234_5678;  // Unaligned on purpose
      raise_requests(NB_SLOTS'(1 << 2));
      wait_drained();
      if (ar_order.size() != ar_mark + 1) begin
         $display("ERROR at %0t: %0d ARs for one miss", $time, ar_order.size() - ar_mark);
         test_errs++;
      end else if (ar_order[ar_mark] !== ID_WIDTH'(2)) begin
         report_mismatch("axi_arid_o", LINE_WIDTH'(ar_order[ar_mark]), LINE_WIDTH'(2));
         test_errs++;
      end
      expect_responses(NB_SLOTS'(1 << 2), 1);
      finish_test();

      start_test("all ports at once");
      random_addrs();
      ready_pct = 70;
      raise_requests('1);
      wait_drained();
      for (int k = 0; k < NB_SLOTS; k++) begin
         if (ar_order.size() <= ar_mark + k) begin
            $display("ERROR at %0t: AR number %0d never came", $time, k);
            test_errs++;
         end else if (ar_order[ar_mark + k] !== ID_WIDTH'(k)) begin
            report_mismatch("axi_arid_o", LINE_WIDTH'(ar_order[ar_mark + k]), LINE_WIDTH'(k));
            test_errs++;
         end
      end
      expect_responses('1, 1);
      finish_test();

      start_test("AR back-pressure");
      ready_pct = 25;
      for (int r = 0; r < STALL_ROUNDS; r++) begin
         random_addrs();
         raise_requests('1);  // Busy slots keep their request waiting
      end
      wait_drained();
      expect_responses('1, STALL_ROUNDS);
      finish_test();

      start_test("prefetch miss");
      ready_pct = 100;
      next_addr[NB_CORES] = 32'hCAFE_F00D;
      raise_requests(NB_SLOTS'(1 << NB_CORES));
      wait_drained();
      expect_responses(NB_SLOTS'(1 << NB_CORES), 1);
      finish_test();

      start_test("random mixed misses");
      ready_pct = 60;
      for (int r = 0; r < RAND_ROUNDS; r++) begin
         random_addrs();
         raise_requests(NB_SLOTS'($urandom()));
         repeat ($urandom % 4) @(posedge clk);
      end
      wait_drained();
      for (int s = 0; s < NB_SLOTS; s++) begin
         if (take_count[s] != resp_count[s]) begin
            $display("ERROR at %0t: %s took %0d misses but answered %0d", $time,
                     port_name(s), take_count[s], resp_count[s]);
            test_errs++;
         end
      end
      finish_test();

      $display("tests run %0d, tests failed %0d, errors %0d", test_count, test_fails,
               test_errs + mon_errs);
      if (test_fails == 0 && test_errs + mon_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/icache_refill_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_top #(
   parameter  int NB_CORES = 4,
   localparam int NB_SLOTS = NB_CORES + 1,
   localparam int ID_WIDTH = $clog2(NB_SLOTS)
) (
   input  logic                                          clk,
   input  logic                                          rst_i,

   // Core fetch ports
   input  logic [NB_CORES-1:0]                           fetch_req_i,
   input  icache_refill_pkg::fetch_addr_t [NB_CORES-1:0] fetch_addr_i,
   output logic [NB_CORES-1:0]                           fetch_gnt_o,
   output logic [NB_CORES-1:0]                           fetch_rvalid_o,
   output icache_refill_pkg::line_t [NB_CORES-1:0]       fetch_rdata_o,

   // Prefetch port, last slot
   input  logic                                          pf_fetch_req_i,
   input  icache_refill_pkg::fetch_addr_t                pf_fetch_addr_i,
   output logic                                          pf_fetch_gnt_o,
   output logic                                          pf_fetch_rvalid_o,
   output icache_refill_pkg::line_t                      pf_fetch_rdata_o,

   // AXI read address channel
   output logic [ID_WIDTH-1:0]                           axi_arid_o,
   output icache_refill_pkg::fetch_addr_t                axi_araddr_o,
   output logic [7:0]                                    axi_arlen_o,
   output logic [2:0]                                    axi_arsize_o,
   output logic [1:0]                                    axi_arburst_o,
   output logic                                          axi_arvalid_o,
   input  logic                                          axi_arready_i,

   // AXI read data channel
   input  logic [ID_WIDTH-1:0]                           axi_rid_i,
   input  icache_refill_pkg::beat_t                      axi_rdata_i,
   input  logic                                          axi_rlast_i,
   input  logic                                          axi_rvalid_i,
   output logic                                          axi_rready_o
);

   import icache_refill_pkg::*;

   // Per-slot view, prefetcher on top index
   logic        [NB_SLOTS-1:0] slot_req;
   fetch_addr_t [NB_SLOTS-1:0] slot_addr;
   logic        [NB_SLOTS-1:0] slot_gnt;
   logic        [NB_SLOTS-1:0] slot_rvalid;
   line_t       [NB_SLOTS-1:0] slot_rdata;

   logic        [NB_SLOTS-1:0] ar_pending;
   fetch_addr_t [NB_SLOTS-1:0] line_addr;   // Aligned miss address per slot
   logic        [NB_SLOTS-1:0] ar_issue;

   logic        [NB_SLOTS-1:0] beat_strobe;
   logic                       beat_last;
   beat_t                      beat_data;

   assign slot_req  = {pf_fetch_req_i, fetch_req_i};
   assign slot_addr = {pf_fetch_addr_i, fetch_addr_i};

   assign fetch_gnt_o       = slot_gnt[NB_CORES-1:0];
   assign fetch_rvalid_o    = slot_rvalid[NB_CORES-1:0];
   assign fetch_rdata_o     = slot_rdata[NB_CORES-1:0];
   assign pf_fetch_gnt_o    = slot_gnt[NB_CORES];
   assign pf_fetch_rvalid_o = slot_rvalid[NB_CORES];
   assign pf_fetch_rdata_o  = slot_rdata[NB_CORES];

   ////////////////////////////////////////
   // R beat router
   ////////////////////////////////////////
   r_beat_router #(
      .NB_CORES      (NB_CORES)
   ) r_beat_router_i (
      .clk           (clk),
      .rst_i         (rst_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rid_i     (axi_rid_i),
      .axi_rdata_i   (axi_rdata_i),
      .axi_rlast_i   (axi_rlast_i),
      .beat_strobe_o (beat_strobe),
      .beat_last_o   (beat_last),
      .beat_data_o   (beat_data)
   );

   ////////////////////////////////////////
   // One miss slot per requester
   ////////////////////////////////////////
   for (genvar g = 0; g < NB_SLOTS; g++) begin : gen_slot
      miss_slot miss_slot_i (
         .clk           (clk),
         .rst_i         (rst_i),
         .req_i         (slot_req[g]),
         .addr_i        (slot_addr[g]),
         .gnt_o         (slot_gnt[g]),
         .rvalid_o      (slot_rvalid[g]),
         .rdata_o       (slot_rdata[g]),
         .ar_pending_o  (ar_pending[g]),
         .line_addr_o   (line_addr[g]),
         .ar_issue_i    (ar_issue[g]),
         .beat_strobe_i (beat_strobe[g]),  // Beats for other IDs pass by
         .beat_last_i   (beat_last),
         .beat_data_i   (beat_data)
      );
   end

   ////////////////////////////////////////
   // AR arbiter and register
   ////////////////////////////////////////
   ar_arbiter #(
      .NB_CORES      (NB_CORES)
   ) ar_arbiter_i (
      .clk           (clk),
      .rst_i         (rst_i),
      .ar_pending_i  (ar_pending),
      .line_addr_i   (line_addr),
      .ar_issue_o    (ar_issue),
      .axi_arready_i (axi_arready_i),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_araddr_o  (axi_araddr_o),
      .axi_arid_o    (axi_arid_o)
   );

   // Every refill is one full line burst
   assign axi_arlen_o   = AXI_ARLEN_LINE;
   assign axi_arsize_o  = AXI_ARSIZE_BEAT;
   assign axi_arburst_o = AXI_ARBURST_INCR;
   assign axi_rready_o  = 1'b1;  // Every slot can always take its beats

endmodule

`default_nettype wire

//--- logic/ar_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ar_arbiter #(
   parameter  int NB_CORES = 4,
   localparam int NB_SLOTS = NB_CORES + 1,
   localparam int ID_WIDTH = $clog2(NB_SLOTS)
) (
   input  logic                                          clk,
   input  logic                                          rst_i,

   // Miss slots
   input  logic [NB_SLOTS-1:0]                           ar_pending_i,
   input  icache_refill_pkg::fetch_addr_t [NB_SLOTS-1:0] line_addr_i,
   output logic [NB_SLOTS-1:0]                           ar_issue_o,

   // AXI AR channel
   input  logic                                          axi_arready_i,
   output logic                                          axi_arvalid_o,
   output icache_refill_pkg::fetch_addr_t                axi_araddr_o,
   output logic [ID_WIDTH-1:0]                           axi_arid_o
);

   import icache_refill_pkg::*;

   logic                arvalid_q;
   fetch_addr_t         araddr_q;
   logic [ID_WIDTH-1:0] arid_q;

   logic                win_found;  // Some slot is pending
   logic [ID_WIDTH-1:0] win_idx;    // Lowest pending index
   logic                ar_free;    // AR register empty or draining
   logic                ar_load;

   ////////////////////////////////////////
   // Fixed priority, lowest index wins
   ////////////////////////////////////////
   always_comb begin
      win_found = 1'b0;
      win_idx   = '0;
      for (int s = 0; s < NB_SLOTS; s++) begin
         if (ar_pending_i[s] && !win_found) begin
            win_found = 1'b1;
            win_idx   = ID_WIDTH'(s);  // Cores first, prefetcher last
         end
      end
   end

   assign ar_free = !arvalid_q || axi_arready_i;
   assign ar_load = ar_free && win_found;

   // Tell the winner it is in the AR register
   always_comb begin
      for (int s = 0; s < NB_SLOTS; s++) begin
         ar_issue_o[s] = ar_load && (win_idx == ID_WIDTH'(s));
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         arvalid_q <= 1'b0;
      end else if (ar_load) begin
         arvalid_q <= 1'b1;
      end else if (axi_arready_i) begin
         arvalid_q <= 1'b0;  // Accepted, nothing behind it
      end
   end

   always_ff @(posedge clk) begin
      if (ar_load) begin
         araddr_q <= line_addr_i[win_idx];
         arid_q   <= win_idx;  // AXI ID is the slot index
      end
   end

   assign axi_arvalid_o = arvalid_q;
   assign axi_araddr_o  = araddr_q;
   assign axi_arid_o    = arid_q;

   // AXI rule, a stalled address must not move
   ar_stable_a : assert property (@(posedge clk) disable iff (rst_i)
      (axi_arvalid_o && !axi_arready_i) |=>
         (axi_arvalid_o && $stable(axi_araddr_o) && $stable(axi_arid_o)));

endmodule

`default_nettype wire

//--- logic/miss_slot.sv
`timescale 1ns/1ps
`default_nettype none

module miss_slot (
   input  logic                           clk,
   input  logic                           rst_i,

   // Requester side
   input  logic                           req_i,
   input  icache_refill_pkg::fetch_addr_t addr_i,
   output logic                           gnt_o,
   output logic                           rvalid_o,     // One-cycle pulse
   output icache_refill_pkg::line_t       rdata_o,      // Held until next response

   // Arbiter side
   output logic                           ar_pending_o,
   output icache_refill_pkg::fetch_addr_t line_addr_o,
   input  logic                           ar_issue_i,   // Slot loaded into AR register

   // Router side
   input  logic                           beat_strobe_i,
   input  logic                           beat_last_i,
   input  icache_refill_pkg::beat_t       beat_data_i
);

   import icache_refill_pkg::*;

   slot_state_e state_q;
   fetch_addr_t addr_q;    // Line aligned miss address
   beat_t       low_q;     // First beat of the line
   line_t       rdata_q;
   logic        rvalid_q;

   logic        req_take;  // Request accepted this cycle

   assign gnt_o    = (state_q == SLOT_IDLE);  // Grant follows request while free
   assign req_take = req_i && gnt_o;

   ////////////////////////////////////////
   // Slot FSM
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q  <= SLOT_IDLE;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= 1'b0;  // Default, pulse only
         case (state_q)
            SLOT_IDLE: begin
               if (req_take) begin
                  state_q <= SLOT_WAIT_AR;
               end
            end
            SLOT_WAIT_AR: begin
               if (ar_issue_i) begin
                  state_q <= SLOT_WAIT_DATA;
               end
            end
            SLOT_WAIT_DATA: begin
               // Last beat completes the line
               if (beat_strobe_i && beat_last_i) begin
                  state_q  <= SLOT_IDLE;
                  rvalid_q <= 1'b1;
               end
            end
            default: state_q <= SLOT_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Address and line assembly
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (req_take) begin
         // Drop byte offset, burst starts at the line base
         addr_q <= {addr_i[FETCH_ADDR_WIDTH-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}};
      end
      if (beat_strobe_i && !beat_last_i) begin
         low_q <= beat_data_i;  // Low half arrives first
      end
      if (beat_strobe_i && beat_last_i) begin
         rdata_q <= {beat_data_i, low_q};
      end
   end

   assign ar_pending_o = (state_q == SLOT_WAIT_AR);
   assign line_addr_o  = addr_q;
   assign rvalid_o     = rvalid_q;
   assign rdata_o      = rdata_q;

   // Router only targets a slot with a burst in flight
   strobe_in_wait_data_a : assert property (@(posedge clk) disable iff (rst_i)
      beat_strobe_i |-> (state_q == SLOT_WAIT_DATA));

   // Arbiter only issues a slot that is pending
   issue_in_wait_ar_a : assert property (@(posedge clk) disable iff (rst_i)
      ar_issue_i |-> (state_q == SLOT_WAIT_AR));

endmodule

`default_nettype wire

//--- logic/r_beat_router.sv
`timescale 1ns/1ps
`default_nettype none

module r_beat_router #(
   parameter  int NB_CORES = 4,
   localparam int NB_SLOTS = NB_CORES + 1,      // Cores plus prefetcher
   localparam int ID_WIDTH = $clog2(NB_SLOTS)   // Binary slot index
) (
   input  logic                        clk,
   input  logic                        rst_i,

   // AXI R channel, never stalled
   input  logic                        axi_rvalid_i,
   input  logic [ID_WIDTH-1:0]         axi_rid_i,
   input  icache_refill_pkg::beat_t    axi_rdata_i,
   input  logic                        axi_rlast_i,

   // Broadcast to all miss slots
   output logic [NB_SLOTS-1:0]         beat_strobe_o,
   output logic                        beat_last_o,
   output icache_refill_pkg::beat_t    beat_data_o
);

   import icache_refill_pkg::*;

   logic                rvalid_q;  // Beat captured last cycle
   logic [ID_WIDTH-1:0] rid_q;
   logic                rlast_q;
   beat_t               rdata_q;

   ////////////////////////////////////////
   // Input register stage
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= axi_rvalid_i;
      end
   end

   // Payload only, qualified by rvalid_q
   always_ff @(posedge clk) begin
      if (axi_rvalid_i) begin
         rid_q   <= axi_rid_i;
         rlast_q <= axi_rlast_i;
         rdata_q <= axi_rdata_i;
      end
   end

   // ID decode to a one-hot slot strobe
   always_comb begin
      for (int s = 0; s < NB_SLOTS; s++) begin
         beat_strobe_o[s] = rvalid_q && (rid_q == ID_WIDTH'(s));
      end
   end

   assign beat_last_o = rlast_q;
   assign beat_data_o = rdata_q;

   // The slave may only answer with IDs that name a slot
   rid_in_range_a : assert property (@(posedge clk) disable iff (rst_i)
      axi_rvalid_i |-> (32'(axi_rid_i) < NB_SLOTS));

endmodule

`default_nettype wire

//--- logic/icache_refill_pkg.sv
`default_nettype none

package icache_refill_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int FETCH_ADDR_WIDTH = 32;   // Byte address
   localparam int LINE_WIDTH       = 128;  // One cache line
   localparam int BEAT_WIDTH       = 64;   // AXI read data bus
   localparam int LINE_OFFSET      = 4;    // Byte offset bits inside a line

   ////////////////////////////////////////
   // AXI burst encodings for a line refill
   ////////////////////////////////////////
   localparam logic [7:0] AXI_ARLEN_LINE   = 8'd1;  // Two beats per line
   localparam logic [2:0] AXI_ARSIZE_BEAT  = 3'd3;  // 8 bytes per beat
   localparam logic [1:0] AXI_ARBURST_INCR = 2'd1;  // Incrementing burst

   typedef logic [FETCH_ADDR_WIDTH-1:0] fetch_addr_t;
   typedef logic [LINE_WIDTH-1:0]       line_t;
   typedef logic [BEAT_WIDTH-1:0]       beat_t;

   // Miss slot life cycle
   typedef enum logic [1:0] {
      SLOT_IDLE,       // Free, grant follows request
      SLOT_WAIT_AR,    // Miss latched, waiting for the AR register
      SLOT_WAIT_DATA   // AR issued, collecting R beats
   } slot_state_e;

endpackage

`default_nettype wire
